// ==== rtl/isaPkg.sv ====
package isaPkg;

	// MIPS instruction field widths
	localparam int opWidth = 6;
	localparam int functWidth = 6;
	localparam int immWidth = 16;
	localparam int aluOpWidth = 3;

	typedef logic [opWidth-1:0] opcode_t;
	typedef logic [functWidth-1:0] funct_t;
	typedef logic [aluOpWidth-1:0] aluOp_t;

	// Primary opcodes
	localparam opcode_t opRegType = 6'h00;
	localparam opcode_t opAddImm = 6'h08;
	localparam opcode_t opLoad = 6'h23;  // lw
	localparam opcode_t opStore = 6'h2B; // sw

	// R-type function codes
	localparam funct_t fnAdd = 6'h20;
	localparam funct_t fnSub = 6'h22;
	localparam funct_t fnAnd = 6'h24;
	localparam funct_t fnOr = 6'h25;
	localparam funct_t fnSlt = 6'h2A;

	// ALU operation select
	localparam aluOp_t aluAdd = 3'd0;
	localparam aluOp_t aluSub = 3'd1;
	localparam aluOp_t aluAnd = 3'd2;
	localparam aluOp_t aluOr = 3'd3;
	localparam aluOp_t aluSlt = 3'd4;

endpackage

// ==== rtl/dataPkg.sv ====
package dataPkg;

	// Register contents, ALU operands and memory data
	typedef logic signed [31:0] word_t;

	typedef logic [31:0] addr_t;   // Byte address
	typedef logic [4:0] regIdx_t;  // r0 .. r31
	typedef logic [31:0] instr_t;

endpackage

// ==== rtl/controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder (
	input  dataPkg::instr_t  instr,
	input  logic             instrValid,
	output dataPkg::regIdx_t rsIdx,
	output dataPkg::regIdx_t rtIdx,
	output dataPkg::regIdx_t destIdx,
	output dataPkg::word_t   immediate,
	output isaPkg::aluOp_t   aluOp,
	output logic             useImm,
	output logic             memWrite,
	output logic             memRead,
	output logic             regWrite
);
	localparam int extBits = $bits(dataPkg::word_t) - isaPkg::immWidth;

	isaPkg::opcode_t opcode;
	isaPkg::funct_t funct;
	dataPkg::regIdx_t rdIdx;
	logic writesReg;

	assign opcode = instr[31:26];
	assign rsIdx = instr[25:21];
	assign rtIdx = instr[20:16];
	assign rdIdx = instr[15:11];
	assign funct = instr[5:0];
	assign immediate = {{extBits{instr[isaPkg::immWidth-1]}}, instr[isaPkg::immWidth-1:0]};

	always_comb begin
		aluOp = isaPkg::aluAdd; // Address calc and addi
		useImm = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		writesReg = 1'b0;
		destIdx = rtIdx;
		case (opcode)
			isaPkg::opLoad: begin
				useImm = 1'b1;
				memRead = 1'b1;
				writesReg = 1'b1;
			end
			isaPkg::opStore: begin
				useImm = 1'b1;
				memWrite = 1'b1;
			end
			isaPkg::opAddImm: begin
				useImm = 1'b1;
				writesReg = 1'b1;
			end
			isaPkg::opRegType: begin
				destIdx = rdIdx;
				writesReg = 1'b1;
				case (funct)
					isaPkg::fnAdd: aluOp = isaPkg::aluAdd;
					isaPkg::fnSub: aluOp = isaPkg::aluSub;
					isaPkg::fnAnd: aluOp = isaPkg::aluAnd;
					isaPkg::fnOr: aluOp = isaPkg::aluOr;
					isaPkg::fnSlt: aluOp = isaPkg::aluSlt;
					default: writesReg = 1'b0; // Unknown funct is a no-op
				endcase
			end
			default: writesReg = 1'b0;
		endcase

		// No strobe without an instruction
		if (!instrValid) begin
			memWrite = 1'b0;
			memRead = 1'b0;
			writesReg = 1'b0;
		end
	end

	assign regWrite = writesReg && (destIdx != '0); // r0 is never written

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input  logic             RESET,
	input  logic             CLK,
	input  dataPkg::regIdx_t rsIdx,
	input  dataPkg::regIdx_t rtIdx,
	output dataPkg::word_t   rsData,
	output dataPkg::word_t   rtData,
	input  logic             writeEn,
	input  dataPkg::regIdx_t writeIdx,
	input  dataPkg::word_t   writeData
);
	localparam int regCount = 32;

	dataPkg::word_t regs [regCount];

	always_ff @(posedge RESET or posedge CLK) begin
		if (CLK) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeIdx != '0) begin
			regs[writeIdx] <= writeData;
		end
	end

	// Write data is forwarded so a dependent instruction sees it in the same cycle
	function automatic dataPkg::word_t readPort(dataPkg::regIdx_t idx);
		if (idx == '0) begin
			return '0;
		end
		if (writeEn && idx == writeIdx) begin
			return writeData;
		end
		return regs[idx];
	endfunction

	always_comb begin
		rsData = readPort(rsIdx);
	end

	always_comb begin
		rtData = readPort(rtIdx);
	end

endmodule

// ==== rtl/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
	input  dataPkg::word_t opA,
	input  dataPkg::word_t opB,
	input  dataPkg::word_t immediate,
	input  logic           useImm,
	input  isaPkg::aluOp_t aluOp,
	output dataPkg::word_t result
);
	dataPkg::word_t opSel;

	assign opSel = useImm ? immediate : opB; // I-type takes the immediate

	always_comb begin
		case (aluOp)
			isaPkg::aluAdd: result = opA + opSel;
			isaPkg::aluSub: result = opA - opSel;
			isaPkg::aluAnd: result = opA & opSel;
			isaPkg::aluOr: result = opA | opSel;
			isaPkg::aluSlt: result = (opA < opSel) ? 32'sd1 : 32'sd0; // Signed compare
			default: result = '0;
		endcase
	end

endmodule

// ==== rtl/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory #(
	parameter int memWords = 64
) (
	input  logic           RESET,
	input  logic           CLK,
	input  dataPkg::addr_t address,
	input  dataPkg::word_t writeData,
	input  logic           memWrite,
	input  logic           memRead,
	output dataPkg::word_t readData
);
	localparam int idxBits = $clog2(memWords);

	dataPkg::word_t mem [memWords];
	logic [idxBits-1:0] wordIdx;

	// Byte offset and bits above the index are dropped
	assign wordIdx = address[idxBits+1:2];

	always_ff @(posedge RESET or posedge CLK) begin
		if (CLK) begin
			for (int i = 0; i < memWords; i++) begin
				mem[i] <= '0;
			end
			readData <= '0;
		end else if (memWrite) begin
			mem[wordIdx] <= writeData; // Write wins over read
			readData <= '0;
		end else if (memRead) begin
			readData <= mem[wordIdx];
		end else begin
			readData <= '0;
		end
	end

endmodule

// ==== rtl/writebackStage.sv ====
`timescale 1ns/1ps

module writebackStage (
	input  logic             RESET,
	input  logic             CLK,
	input  logic             regWrite,
	input  logic             fromMem,
	input  dataPkg::regIdx_t destIdx,
	input  dataPkg::word_t   aluResult,
	input  dataPkg::word_t   readData,
	output logic             wbValid,
	output dataPkg::regIdx_t wbReg,
	output dataPkg::word_t   wbData
);
	logic wbFromMem;
	dataPkg::word_t aluHeld;

	always_ff @(posedge RESET or posedge CLK) begin
		if (CLK) begin
			wbValid <= 1'b0;
			wbFromMem <= 1'b0;
			wbReg <= '0;
			aluHeld <= '0;
		end else begin
			wbValid <= regWrite;
			wbFromMem <= fromMem;
			wbReg <= destIdx;
			aluHeld <= aluResult;
		end
	end

	// Memory data arrives registered, aligned with the held ALU result
	assign wbData = wbFromMem ? readData : aluHeld;

endmodule

// ==== rtl/loadStoreCore.sv ====
`timescale 1ns/1ps

module loadStoreCore #(
	parameter int memWords = 64
) (
	input  logic             RESET,
	input  logic             CLK,
	input  dataPkg::instr_t  instr,
	input  logic             instrValid,
	output logic             wbValid,
	output dataPkg::regIdx_t wbReg,
	output dataPkg::word_t   wbData
);
	dataPkg::regIdx_t rsIdx;
	dataPkg::regIdx_t rtIdx;
	dataPkg::regIdx_t destIdx;
	dataPkg::word_t immediate;
	dataPkg::word_t rsData;
	dataPkg::word_t rtData;
	dataPkg::word_t aluResult;
	dataPkg::word_t readData;
	dataPkg::addr_t memAddr;
	isaPkg::aluOp_t aluOp;
	logic useImm;
	logic memWrite;
	logic memRead;
	logic regWrite;

	assign memAddr = dataPkg::addr_t'(aluResult); // ALU result doubles as byte address

	controlDecoder decoder (
		.instr(instr), .instrValid(instrValid),
		.rsIdx(rsIdx), .rtIdx(rtIdx), .destIdx(destIdx),
		.immediate(immediate), .aluOp(aluOp), .useImm(useImm),
		.memWrite(memWrite), .memRead(memRead), .regWrite(regWrite)
	);

	registerFile regFile (
		.RESET(RESET), .CLK(CLK),
		.rsIdx(rsIdx), .rtIdx(rtIdx), .rsData(rsData), .rtData(rtData),
		.writeEn(wbValid), .writeIdx(wbReg), .writeData(wbData)
	);

	aluUnit alu (
		.opA(rsData), .opB(rtData), .immediate(immediate),
		.useImm(useImm), .aluOp(aluOp), .result(aluResult)
	);

	dataMemory #(.memWords(memWords)) dmem (
		.RESET(RESET), .CLK(CLK),
		.address(memAddr), .writeData(rtData),
		.memWrite(memWrite), .memRead(memRead), .readData(readData)
	);

	writebackStage wb (
		.RESET(RESET), .CLK(CLK),
		.regWrite(regWrite), .fromMem(memRead), .destIdx(destIdx),
		.aluResult(aluResult), .readData(readData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

endmodule

// ==== dv/tb_loadStoreCore.sv ====
`timescale 1ns/1ps

module tb_loadStoreCore;

	localparam int memWords = 64;
	localparam int maxLines = 256;
	localparam int clockPeriod = 100;
	localparam int resetCycles = 5;
	localparam string stimPath = "dv/loadStoreCore_stim.txt";

	// instr[75:44] flag[43:40] reg[39:32] data[31:0]
	typedef logic [75:0] stimLine_t;

	logic RESET; // DUT clock
	logic CLK;   // DUT reset, active high
	dataPkg::instr_t instr;
	logic instrValid;
	logic wbValid;
	dataPkg::regIdx_t wbReg;
	dataPkg::word_t wbData;

	stimLine_t stimMem [maxLines];
	int lineCount;
	int mismatchCount;
	int otherErrors;
	int checkCount;
	bit loadDone;

	loadStoreCore #(.memWords(memWords)) uut (
		.RESET(RESET), .CLK(CLK),
		.instr(instr), .instrValid(instrValid),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	always #(clockPeriod / 2) RESET = ~RESET;

	// Short name of an instruction for error lines
	function automatic string mnemonicOf(dataPkg::instr_t word);
		isaPkg::opcode_t op;
		isaPkg::funct_t fn;
		string name;
		op = word[31:26];
		fn = word[5:0];
		case (op)
			isaPkg::opLoad: name = "lw";
			isaPkg::opStore: name = "sw";
			isaPkg::opAddImm: name = "addi";
			isaPkg::opRegType: begin
				case (fn)
					isaPkg::fnAdd: name = "add";
					isaPkg::fnSub: name = "sub";
					isaPkg::fnAnd: name = "and";
					isaPkg::fnOr: name = "or";
					isaPkg::fnSlt: name = "slt";
					default: name = "bad funct";
				endcase
			end
			default: name = "bad opcode";
		endcase
		return name;
	endfunction

	task automatic checkFlag(input string testName, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			$display("mismatch %s: expected %0b, actual %0b", testName, expected, actual);
			mismatchCount++;
		end
	endtask

	task automatic checkReg(input string testName, input dataPkg::regIdx_t expected,
			input dataPkg::regIdx_t actual);
		checkCount++;
		if (actual !== expected) begin
			$display("mismatch %s: expected r%0d, actual r%0d", testName, expected, actual);
			mismatchCount++;
		end
	endtask

	task automatic checkWord(input string testName, input dataPkg::word_t expected,
			input dataPkg::word_t actual);
		checkCount++;
		if (actual !== expected) begin
			$display("mismatch %s: expected 0x%08h (%0d), actual 0x%08h (%0d)",
				testName, expected, expected, actual, actual);
			mismatchCount++;
		end
	endtask

	task automatic loadStim();
		int fd;
		stimLine_t entry;
		lineCount = 0;
		fd = $fopen(stimPath, "r");
		if (fd == 0) begin
			$display("error: cannot open stim file %s", stimPath);
			otherErrors++;
			return;
		end
		$fclose(fd);

		// All-ones fill marks entries the file did not reach
		for (int i = 0; i < maxLines; i++) begin
			stimMem[i] = '1;
		end
		$readmemh(stimPath, stimMem);
		while (lineCount < maxLines && stimMem[lineCount][43:40] != 4'hF) begin
			lineCount++;
		end
		if (lineCount == 0) begin
			$display("error: stim file %s holds no test lines", stimPath);
			otherErrors++;
		end

		for (int i = 0; i < lineCount; i++) begin
			entry = stimMem[i];
			if (entry[43:41] != 3'd0 || entry[39:37] != 3'd0) begin
				$display("error: stim line %0d has a bad flag or register field", i + 1);
				otherErrors++;
			end
		end
	endtask

	task automatic driveLine(input int idx);
		instr = stimMem[idx][75:44];
		instrValid = 1'b1;
	endtask

	// Last word stays on the bus, only the strobe drops
	task automatic driveIdle();
		instrValid = 1'b0;
	endtask

	// Writeback of line idx, seen one cycle after it was strobed
	task automatic checkResult(input int idx);
		stimLine_t entry;
		string testName;
		entry = stimMem[idx];
		testName = $sformatf("test %0d %s", idx + 1, mnemonicOf(entry[75:44]));
		checkFlag({testName, " wbValid"}, entry[40], wbValid);
		if (entry[40]) begin
			checkReg({testName, " wbReg"}, entry[36:32], wbReg);
			checkWord({testName, " wbData"}, entry[31:0], wbData);
		end
	endtask

	// Back to back, one instruction per cycle
	task automatic runStim();
		driveLine(0);
		for (int k = 1; k <= lineCount; k++) begin
			@(negedge RESET);
			checkResult(k - 1);
			if (k < lineCount) begin
				driveLine(k);
			end else begin
				driveIdle();
			end
		end
		@(negedge RESET);
		checkFlag("idle after last test wbValid", 1'b0, wbValid);
	endtask

	initial begin
		RESET = 1'b0;
		CLK = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		mismatchCount = 0;
		otherErrors = 0;
		checkCount = 0;
		loadDone = 1'b0;

		loadStim();
		loadDone = 1'b1;

		repeat (resetCycles) @(negedge RESET);
		CLK = 1'b0;
		if (lineCount > 0) begin
			runStim();
		end

		$display("checks %0d, mismatches %0d, other errors %0d",
			checkCount, mismatchCount, otherErrors);
		if (mismatchCount == 0 && otherErrors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Watchdog, sized from the number of stim lines
	initial begin
		int timeoutNs;
		wait (loadDone);
		timeoutNs = (lineCount + resetCycles + 10) * clockPeriod * 2;
		#(timeoutNs);
		$display("error: run did not finish within %0d ns", timeoutNs);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== dv/loadStoreCore_stim.txt ====
// Columns: instruction _ expected wbValid _ expected wbReg _ expected wbData (all hex)
// One instruction per line, strobed back to back; reg and data are ignored when wbValid is 0
// Loads right after reset
8C010000_1_01_00000000  // lw   r1, 0x00(r0)
8C020004_1_02_00000000  // lw   r2, 0x04(r0)
8C0300FC_1_03_00000000  // lw   r3, 0xFC(r0)
8C040080_1_04_00000000  // lw   r4, 0x80(r0)
// Arithmetic on signed operands
20010064_1_01_00000064  // addi r1, r0, 100
2002FFF9_1_02_FFFFFFF9  // addi r2, r0, -7
2023FF6A_1_03_FFFFFFCE  // addi r3, r1, -150
00222020_1_04_0000005D  // add  r4, r1, r2
00412822_1_05_FFFFFF95  // sub  r5, r2, r1
00223024_1_06_00000060  // and  r6, r1, r2
00223825_1_07_FFFFFFFD  // or   r7, r1, r2
0041402A_1_08_00000001  // slt  r8, r2, r1
0022482A_1_09_00000000  // slt  r9, r1, r2
0062502A_1_0A_00000001  // slt  r10, r3, r2
// Stores and later loads
AC010008_0_00_00000000  // sw   r1, 0x08(r0)
AC070010_0_00_00000000  // sw   r7, 0x10(r0)
200B1234_1_0B_00001234  // addi r11, r0, 0x1234
8C0C0008_1_0C_00000064  // lw   r12, 0x08(r0)
8C0D0010_1_0D_FFFFFFFD  // lw   r13, 0x10(r0)
AC050020_0_00_00000000  // sw   r5, 0x20(r0)
8C0E0020_1_0E_FFFFFF95  // lw   r14, 0x20(r0)
// Dependent instructions through the bypass
20050005_1_05_00000005  // addi r5, r0, 5
00A57820_1_0F_0000000A  // add  r15, r5, r5
01E58022_1_10_00000005  // sub  r16, r15, r5
8C110008_1_11_00000064  // lw   r17, 0x08(r0)
22320001_1_12_00000065  // addi r18, r17, 1
2013FFFF_1_13_FFFFFFFF  // addi r19, r0, -1
AC130030_0_00_00000000  // sw   r19, 0x30(r0)
8C140030_1_14_FFFFFFFF  // lw   r20, 0x30(r0)
// Register 0 and unknown encodings
2000004D_0_00_00000000  // addi r0, r0, 77
0000A820_1_15_00000000  // add  r21, r0, r0
00220020_0_00_00000000  // add  r0, r1, r2
FC21FFFF_0_00_00000000  // opcode 0x3F
0022A83F_0_00_00000000  // R-type funct 0x3F
20360000_1_16_00000064  // addi r22, r1, 0
0001B825_1_17_00000064  // or   r23, r0, r1
// Address aliasing, word 16 and word 63
20185A5A_1_18_00005A5A  // addi r24, r0, 0x5A5A
AC180043_0_00_00000000  // sw   r24, 0x43(r0)
8C190040_1_19_00005A5A  // lw   r25, 0x40(r0)
8C1A0141_1_1A_00005A5A  // lw   r26, 0x141(r0)
8C1B0242_1_1B_00005A5A  // lw   r27, 0x242(r0)
AC0B01FC_0_00_00000000  // sw   r11, 0x1FC(r0)
8C1C00FE_1_1C_00001234  // lw   r28, 0xFE(r0)
8C1DFFFC_1_1D_00001234  // lw   r29, -4(r0)
8C3E0098_1_1E_00001234  // lw   r30, 0x98(r1)
0040F82A_1_1F_00000001  // slt  r31, r2, r0

// ==== flist.f ====
rtl/isaPkg.sv
rtl/dataPkg.sv
rtl/controlDecoder.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/dataMemory.sv
rtl/writebackStage.sv
rtl/loadStoreCore.sv
dv/tb_loadStoreCore.sv

// ==== Makefile ====
TOOL   = verilator
FLAGS  = --binary --timing -j 0
TOP    = tb_loadStoreCore
FLIST  = flist.f
OBJDIR = obj_dir
SIM    = $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# Passes only if the simulation prints the pass message
run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)
